// File: logic/rob_settings.svh
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// number of reorder buffer entries
// any power of two from 4 to 32
`define ROB_DEPTH 8

// entry index width, derived from the depth
`define ROB_TAG_W $clog2(`ROB_DEPTH)

// data, address and pc width
`define XLEN 32

`endif

// File: logic/rob_pkg.sv
`include "rob_settings.svh"

package rob_pkg;

    typedef logic [`XLEN-1:0]      word_t;
    typedef logic [`ROB_TAG_W-1:0] tag_t;
    typedef logic [4:0]            reg_idx_t;

    // what kind of retirement an entry needs
    typedef logic [1:0] op_kind_t;
    localparam op_kind_t OP_REG    = 2'd0;
    localparam op_kind_t OP_STORE  = 2'd1;
    localparam op_kind_t OP_BRANCH = 2'd2;
    localparam op_kind_t OP_JALR   = 2'd3;

    // store width, code 3 is unused
    typedef logic [1:0] store_size_t;
    localparam store_size_t SZ_BYTE = 2'd0;
    localparam store_size_t SZ_HALF = 2'd1;
    localparam store_size_t SZ_WORD = 2'd2;

    typedef enum logic [1:0] {
        C_IDLE,
        C_STORE_REQ,
        C_STORE_RELEASE
    } commit_state_t;

endpackage

// File: logic/rob_pointers.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_pointers
    import rob_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic alloc_valid,
    input  logic retire,
    input  logic flush,
    output tag_t alloc_tag,
    output tag_t head_tag,
    output logic full,
    output logic empty
);

    tag_t                tail_ptr;
    tag_t                head_ptr;
    logic [`ROB_TAG_W:0] count;

    // both pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail_ptr <= '0;
            head_ptr <= '0;
            count    <= '0;
        end else if (flush) begin
            tail_ptr <= '0;
            head_ptr <= '0;
            count    <= '0;
        end else begin
            if (alloc_valid) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (retire) begin
                head_ptr <= head_ptr + 1'b1;
            end
            // allocate and retire together leave the count alone
            case ({alloc_valid, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign alloc_tag = tail_ptr;
    assign head_tag  = head_ptr;
    assign full      = (count == `ROB_DEPTH);
    assign empty     = (count == '0);

    // the allocating side must honour full
    a_no_alloc_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) !(alloc_valid && full && !flush)
    ) else $error("allocation while the reorder buffer is full");

    // the commit machine only retires a ready head, which is never absent
    a_no_retire_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n) !(retire && empty)
    ) else $error("retire while the reorder buffer is empty");

endmodule

// File: logic/rob_entries.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_entries
    import rob_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    // allocation
    input  logic        alloc_valid,
    input  tag_t        alloc_tag,
    input  op_kind_t    alloc_kind,
    input  reg_idx_t    alloc_dest,
    input  store_size_t alloc_size,
    // result bus
    input  logic        cdb_valid,
    input  tag_t        cdb_tag,
    input  word_t       cdb_value,
    input  word_t       cdb_addr,
    input  logic        cdb_mispredict,
    input  word_t       cdb_target,
    // operand lookup
    input  tag_t        lookup_tag,
    output logic        lookup_ready,
    output word_t       lookup_value,
    // commit side
    input  tag_t        head_tag,
    input  logic        retire,
    input  logic        flush,
    output logic        head_ready,
    output op_kind_t    head_kind,
    output reg_idx_t    head_dest,
    output word_t       head_value,
    output word_t       head_addr,
    output store_size_t head_size,
    output logic        head_mispredict,
    output word_t       head_target
);

    // per-entry control bits
    logic [`ROB_DEPTH-1:0] busy;
    logic [`ROB_DEPTH-1:0] ready;

    // per-entry payload
    op_kind_t    kind       [`ROB_DEPTH];
    reg_idx_t    dest       [`ROB_DEPTH];
    store_size_t size       [`ROB_DEPTH];
    word_t       value      [`ROB_DEPTH];
    word_t       addr       [`ROB_DEPTH];
    logic        mispredict [`ROB_DEPTH];
    word_t       target     [`ROB_DEPTH];

    logic bypass_hit;

    // alloc never lands on the head while a retire is pending,
    // so the three updates below touch different entries
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= '0;
            ready <= '0;
        end else if (flush) begin
            busy  <= '0;
            ready <= '0;
        end else begin
            if (alloc_valid) begin
                busy[alloc_tag]  <= 1'b1;
                ready[alloc_tag] <= 1'b0;
            end
            if (cdb_valid) begin
                ready[cdb_tag] <= 1'b1;
            end
            if (retire) begin
                busy[head_tag]  <= 1'b0;
                ready[head_tag] <= 1'b0;
            end
        end
    end

    // static fields at allocation, results from the bus
    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            kind[alloc_tag] <= alloc_kind;
            dest[alloc_tag] <= alloc_dest;
            size[alloc_tag] <= alloc_size;
        end
        if (cdb_valid) begin
            value[cdb_tag]      <= cdb_value;
            addr[cdb_tag]       <= cdb_addr;
            mispredict[cdb_tag] <= cdb_mispredict;
            target[cdb_tag]     <= cdb_target;
        end
    end

    // lookup sees a result on the bus in the same cycle
    assign bypass_hit = cdb_valid && (cdb_tag == lookup_tag);

    always_comb begin
        if (bypass_hit) begin
            lookup_ready = 1'b1;
            lookup_value = cdb_value;
        end else begin
            lookup_ready = ready[lookup_tag];
            lookup_value = value[lookup_tag];
        end
    end

    // head readout, registered state only
    assign head_ready      = ready[head_tag];
    assign head_kind       = kind[head_tag];
    assign head_dest       = dest[head_tag];
    assign head_value      = value[head_tag];
    assign head_addr       = addr[head_tag];
    assign head_size       = size[head_tag];
    assign head_mispredict = mispredict[head_tag];
    assign head_target     = target[head_tag];

    // results only come back for instructions still in flight
    a_cdb_hits_busy: assert property (
        @(posedge clk) disable iff (!rst_n) cdb_valid |-> busy[cdb_tag]
    ) else $error("result bus wrote tag %0d which is not allocated", cdb_tag);

endmodule

// File: logic/store_align.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module store_align
    import rob_pkg::*;
(
    input  word_t       head_addr,
    input  store_size_t head_size,
    input  word_t       head_value,
    output logic [3:0]  mem_be,
    output word_t       store_word
);

    logic [1:0]        offset;
    logic [2*`XLEN-1:0] doubled;

    assign offset = head_addr[1:0];

    // lane selection
    always_comb begin
        case (head_size)
            SZ_BYTE: mem_be = 4'b0001 << offset;
            SZ_HALF: mem_be = offset[1] ? 4'b1100 : 4'b0011;
            SZ_WORD: mem_be = 4'b1111;
            default: mem_be = 4'b1111;
        endcase
    end

    // rotate left by whole bytes, the upper half of the shifted pair
    // holds the rotated word so byte k ends up in lane k+offset
    assign doubled    = {head_value, head_value} << (8 * offset);
    assign store_word = doubled[2*`XLEN-1 -: `XLEN];

endmodule

// File: logic/commit_fsm.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module commit_fsm
    import rob_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // head entry
    input  logic       head_ready,
    input  op_kind_t   head_kind,
    input  reg_idx_t   head_dest,
    input  word_t      head_value,
    input  logic       head_mispredict,
    input  word_t      head_target,
    input  word_t      head_addr,
    input  tag_t       head_tag,
    // aligned store from store_align
    input  word_t      store_word,
    input  logic [3:0] mem_be_in,
    // memory
    input  logic       mem_ack,
    // buffer control
    output logic       retire,
    output logic       flush,
    output word_t      redirect_pc,
    // register commit
    output logic       commit_valid,
    output reg_idx_t   commit_rd,
    output word_t      commit_value,
    output tag_t       commit_tag,
    // store port
    output logic       mem_req,
    output word_t      mem_addr,
    output word_t      mem_wdata,
    output logic [3:0] mem_be
);

    commit_state_t state;
    commit_state_t state_next;

    logic idle_ready;
    logic head_is_store;
    logic writes_reg;
    logic redirects;
    logic store_start;

    assign idle_ready    = (state == C_IDLE) && head_ready;
    assign head_is_store = (head_kind == OP_STORE);
    assign writes_reg    = (head_kind == OP_REG) || (head_kind == OP_JALR);
    assign redirects     = ((head_kind == OP_BRANCH) || (head_kind == OP_JALR))
                           && head_mispredict;
    assign store_start   = idle_ready && head_is_store;

    always_comb begin
        state_next = state;
        case (state)
            C_IDLE: begin
                if (store_start) begin
                    state_next = C_STORE_REQ;
                end
            end
            C_STORE_REQ: begin
                if (mem_ack) begin
                    state_next = C_STORE_RELEASE;
                end
            end
            C_STORE_RELEASE: begin
                if (!mem_ack) begin
                    state_next = C_IDLE;
                end
            end
            default: state_next = C_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= C_IDLE;
            mem_req <= 1'b0;
        end else begin
            state <= state_next;
            if (store_start) begin
                mem_req <= 1'b1;
            end else if ((state == C_STORE_REQ) && mem_ack) begin
                mem_req <= 1'b0;
            end
        end
    end

    // captured once per store, held through the whole handshake
    always_ff @(posedge clk) begin
        if (store_start) begin
            mem_addr  <= {head_addr[`XLEN-1:2], 2'b00};
            mem_wdata <= store_word;
            mem_be    <= mem_be_in;
        end
    end

    // non-stores leave in the cycle they become ready,
    // a store leaves once the memory has dropped ack
    assign retire = (idle_ready && !head_is_store)
                    || ((state == C_STORE_RELEASE) && !mem_ack);

    assign commit_valid = idle_ready && writes_reg;
    assign commit_rd    = head_dest;
    assign commit_value = head_value;
    assign commit_tag   = head_tag;

    assign flush       = idle_ready && redirects;
    assign redirect_pc = head_target;

    // four-phase rule, the memory only acknowledges an open request
    a_ack_follows_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(mem_ack) |-> mem_req
    ) else $error("mem_ack rose without a pending mem_req");

endmodule

// File: logic/rob_top.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_top
    import rob_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    // allocation
    input  logic        alloc_valid,
    input  op_kind_t    alloc_kind,
    input  reg_idx_t    alloc_dest,
    input  store_size_t alloc_size,
    output tag_t        alloc_tag,
    output logic        full,
    output logic        empty,
    // result bus
    input  logic        cdb_valid,
    input  tag_t        cdb_tag,
    input  word_t       cdb_value,
    input  word_t       cdb_addr,
    input  logic        cdb_mispredict,
    input  word_t       cdb_target,
    // operand lookup
    input  tag_t        lookup_tag,
    output logic        lookup_ready,
    output word_t       lookup_value,
    // register commit
    output logic        commit_valid,
    output reg_idx_t    commit_rd,
    output word_t       commit_value,
    output tag_t        commit_tag,
    // store port
    output logic        mem_req,
    output word_t       mem_addr,
    output word_t       mem_wdata,
    output logic [3:0]  mem_be,
    input  logic        mem_ack,
    // redirect
    output logic        flush,
    output word_t       redirect_pc
);

    tag_t        head_tag;
    logic        retire;
    logic        head_ready;
    op_kind_t    head_kind;
    reg_idx_t    head_dest;
    word_t       head_value;
    word_t       head_addr;
    store_size_t head_size;
    logic        head_mispredict;
    word_t       head_target;
    logic [3:0]  store_be;
    word_t       store_word;

    rob_pointers u_rob_pointers (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc_valid (alloc_valid),
        .retire      (retire),
        .flush       (flush),
        .alloc_tag   (alloc_tag),
        .head_tag    (head_tag),
        .full        (full),
        .empty       (empty)
    );

    rob_entries u_rob_entries (
        .clk             (clk),
        .rst_n           (rst_n),
        .alloc_valid     (alloc_valid),
        .alloc_tag       (alloc_tag),
        .alloc_kind      (alloc_kind),
        .alloc_dest      (alloc_dest),
        .alloc_size      (alloc_size),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_value       (cdb_value),
        .cdb_addr        (cdb_addr),
        .cdb_mispredict  (cdb_mispredict),
        .cdb_target      (cdb_target),
        .lookup_tag      (lookup_tag),
        .lookup_ready    (lookup_ready),
        .lookup_value    (lookup_value),
        .head_tag        (head_tag),
        .retire          (retire),
        .flush           (flush),
        .head_ready      (head_ready),
        .head_kind       (head_kind),
        .head_dest       (head_dest),
        .head_value      (head_value),
        .head_addr       (head_addr),
        .head_size       (head_size),
        .head_mispredict (head_mispredict),
        .head_target     (head_target)
    );

    store_align u_store_align (
        .head_addr  (head_addr),
        .head_size  (head_size),
        .head_value (head_value),
        .mem_be     (store_be),
        .store_word (store_word)
    );

    commit_fsm u_commit_fsm (
        .clk             (clk),
        .rst_n           (rst_n),
        .head_ready      (head_ready),
        .head_kind       (head_kind),
        .head_dest       (head_dest),
        .head_value      (head_value),
        .head_mispredict (head_mispredict),
        .head_target     (head_target),
        .head_addr       (head_addr),
        .head_tag        (head_tag),
        .store_word      (store_word),
        .mem_be_in       (store_be),
        .mem_ack         (mem_ack),
        .retire          (retire),
        .flush           (flush),
        .redirect_pc     (redirect_pc),
        .commit_valid    (commit_valid),
        .commit_rd       (commit_rd),
        .commit_value    (commit_value),
        .commit_tag      (commit_tag),
        .mem_req         (mem_req),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_be          (mem_be)
    );

endmodule

// File: testbench/rob_checker.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_checker
    import rob_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       commit_valid,
    input reg_idx_t   commit_rd,
    input word_t      commit_value,
    input tag_t       commit_tag,
    input logic       mem_req,
    input logic       mem_ack,
    input word_t      mem_addr,
    input word_t      mem_wdata,
    input logic [3:0] mem_be,
    input logic       flush,
    input word_t      redirect_pc,
    input logic       full,
    input logic       empty,
    input tag_t       alloc_tag,
    input logic       lookup_ready,
    input word_t      lookup_value
);

    // expected retirements in program order, kind 0 commit, 1 store, 2 flush
    int    ev_kind [$];
    word_t ev_a [$];
    word_t ev_b [$];
    word_t ev_c [$];

    int error_count = 0;
    int check_count = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int errors_at_start = 0;

    // one-shot checks, armed for the next rising edge
    logic  status_armed = 1'b0;
    logic  idle_armed = 1'b0;
    logic  lookup_armed = 1'b0;
    logic  exp_full;
    tag_t  exp_tag;
    logic  exp_ready;
    word_t exp_value;

    logic                in_store;
    logic [2*`XLEN+3:0] held;

    function automatic string kind_name(input int kind);
        case (kind)
            0:       return "register commit";
            1:       return "store request";
            default: return "flush";
        endcase
    endfunction

    function automatic int pending_events();
        return ev_kind.size();
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_problem(input string msg);
        error_count++;
        $display("ERROR at %0d ns: %s", $time, msg);
    endtask

    task automatic push_event(input int kind, input word_t a, input word_t b, input word_t c);
        ev_kind.push_back(kind);
        ev_a.push_back(a);
        ev_b.push_back(b);
        ev_c.push_back(c);
    endtask

    task automatic expect_commit(input reg_idx_t rd, input word_t value, input tag_t tag);
        push_event(0, rd, value, tag);
    endtask

    task automatic expect_store(input word_t addr, input word_t wdata, input logic [3:0] be);
        push_event(1, addr, wdata, be);
    endtask

    task automatic expect_flush(input word_t pc);
        push_event(2, pc, '0, '0);
    endtask

    task automatic expect_status(input logic f, input tag_t t);
        exp_full     = f;
        exp_tag      = t;
        status_armed = 1'b1;
    endtask

    task automatic expect_idle();
        idle_armed = 1'b1;
    endtask

    task automatic expect_lookup(input logic rdy, input word_t value);
        exp_ready    = rdy;
        exp_value    = value;
        lookup_armed = 1'b1;
    endtask

    task automatic take_event(input int kind, input word_t a, input word_t b, input word_t c);
        int    k;
        word_t ea;
        word_t eb;
        word_t ec;
        if (ev_kind.size() == 0) begin
            report_problem($sformatf("unexpected %s, nothing was due", kind_name(kind)));
            return;
        end
        k  = ev_kind.pop_front();
        ea = ev_a.pop_front();
        eb = ev_b.pop_front();
        ec = ev_c.pop_front();
        if (k != kind) begin
            report_problem($sformatf("saw %s while %s was due", kind_name(kind), kind_name(k)));
            return;
        end
        case (kind)
            0: begin
                check_value("commit_rd", a, ea);
                check_value("commit_value", b, eb);
                check_value("commit_tag", c, ec);
            end
            1: begin
                check_value("mem_addr", a, ea);
                check_value("mem_wdata", b, eb);
                check_value("mem_be", c, ec);
            end
            default: check_value("redirect_pc", a, ea);
        endcase
    endtask

    task automatic finish_test(input string name);
        int errs;
        if (ev_kind.size() != 0) begin
            report_problem($sformatf("%0d expected retirements never happened", ev_kind.size()));
            ev_kind.delete();
            ev_a.delete();
            ev_b.delete();
            ev_c.delete();
        end
        errs = error_count - errors_at_start;
        if (errs == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("test %s: %s with %0d errors", name, (errs == 0) ? "passed" : "failed", errs);
        errors_at_start = error_count;
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_store <= 1'b0;
        end else begin
            if (commit_valid) begin
                if (mem_req || mem_ack) begin
                    report_problem("register commit while a store handshake is open");
                end
                take_event(0, commit_rd, commit_value, commit_tag);
            end
            // store outputs are compared once at the rise of mem_req, then must hold
            if (mem_req && !in_store) begin
                take_event(1, mem_addr, mem_wdata, mem_be);
                held     <= {mem_addr, mem_wdata, mem_be};
                in_store <= 1'b1;
            end else if (in_store) begin
                if ({mem_addr, mem_wdata, mem_be} !== held) begin
                    report_problem("store address, data or enables changed during the handshake");
                end
                if (!mem_req && !mem_ack) begin
                    in_store <= 1'b0;
                end
            end
            if (flush) begin
                take_event(2, redirect_pc, '0, '0);
            end
            if (status_armed) begin
                check_value("full", full, exp_full);
                check_value("alloc_tag", alloc_tag, exp_tag);
                status_armed = 1'b0;
            end
            if (idle_armed) begin
                check_value("commit_valid", commit_valid, 1'b0);
                check_value("flush", flush, 1'b0);
                check_value("mem_req", mem_req, 1'b0);
                check_value("empty", empty, 1'b1);
                idle_armed = 1'b0;
            end
            if (lookup_armed) begin
                check_value("lookup_ready", lookup_ready, exp_ready);
                if (exp_ready) begin
                    check_value("lookup_value", lookup_value, exp_value);
                end
                lookup_armed = 1'b0;
            end
        end
    end

endmodule

// File: testbench/rob_tb.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_tb
    import rob_pkg::*;
();

    logic        clk;
    logic        rst_n;
    logic        alloc_valid;
    op_kind_t    alloc_kind;
    reg_idx_t    alloc_dest;
    store_size_t alloc_size;
    tag_t        alloc_tag;
    logic        full;
    logic        empty;
    logic        cdb_valid;
    tag_t        cdb_tag;
    word_t       cdb_value;
    word_t       cdb_addr;
    logic        cdb_mispredict;
    word_t       cdb_target;
    tag_t        lookup_tag;
    logic        lookup_ready;
    word_t       lookup_value;
    logic        commit_valid;
    reg_idx_t    commit_rd;
    word_t       commit_value;
    tag_t        commit_tag;
    logic        mem_req;
    word_t       mem_addr;
    word_t       mem_wdata;
    logic [3:0]  mem_be;
    logic        mem_ack;
    logic        flush;
    word_t       redirect_pc;

    // model of what each allocated entry will receive from the bus
    word_t mdl_value [`ROB_DEPTH];
    word_t mdl_addr  [`ROB_DEPTH];
    logic  mdl_mp    [`ROB_DEPTH];
    word_t mdl_tgt   [`ROB_DEPTH];
    logic  mdl_ready [`ROB_DEPTH];
    tag_t  model_tag;
    tag_t  pending_tags [$];
    int    ack_delays [$];

    rob_top u_rob_top (.*);

    rob_checker u_chk (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // lanes covered by a naturally aligned access of 1, 2 or 4 bytes
    function automatic logic [3:0] expect_be(input word_t addr, input store_size_t size);
        int         nbytes;
        int         first;
        logic [3:0] be;
        nbytes = 1 << size;
        first  = int'(addr[1:0]) & ~(nbytes - 1);
        be     = '0;
        for (int lane = 0; lane < 4; lane++) begin
            if (lane >= first && lane < first + nbytes) begin
                be[lane] = 1'b1;
            end
        end
        return be;
    endfunction

    // byte k of the value goes to lane (k + offset) mod 4
    function automatic word_t expect_wdata(input word_t value, input word_t addr);
        word_t w;
        int    lane;
        for (int k = 0; k < 4; k++) begin
            lane = (k + int'(addr[1:0])) % 4;
            w[8*lane +: 8] = value[8*k +: 8];
        end
        return w;
    endfunction

    function automatic logic flush_expected(input op_kind_t kind, input logic mp);
        return mp && (kind == OP_BRANCH || kind == OP_JALR);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic alloc_op(input op_kind_t kind, input reg_idx_t dest, input store_size_t size,
                            input word_t value, input word_t addr, input logic mp,
                            input word_t tgt, input logic live);
        tag_t t;
        t            = model_tag;
        mdl_value[t] = value;
        mdl_addr[t]  = addr;
        mdl_mp[t]    = mp;
        mdl_tgt[t]   = tgt;
        mdl_ready[t] = 1'b0;
        alloc_valid  = 1'b1;
        alloc_kind   = kind;
        alloc_dest   = dest;
        alloc_size   = size;
        u_chk.expect_status(1'b0, t);
        // ops behind a mispredict are allocated but never expected to retire
        if (live) begin
            if (kind == OP_REG || kind == OP_JALR) begin
                u_chk.expect_commit(dest, value, t);
            end
            if (kind == OP_STORE) begin
                u_chk.expect_store(addr & ~word_t'(3), expect_wdata(value, addr),
                                   expect_be(addr, size));
                ack_delays.push_back($urandom_range(5, 0));
            end
            if (flush_expected(kind, mp)) begin
                u_chk.expect_flush(tgt);
            end
        end
        pending_tags.push_back(t);
        next_cycle();
        alloc_valid = 1'b0;
        model_tag   = tag_t'((int'(t) + 1) % `ROB_DEPTH);
    endtask

    task automatic alloc_random_reg(input logic live);
        alloc_op(OP_REG, reg_idx_t'($urandom_range(31, 1)), SZ_WORD, $urandom, '0, 1'b0, '0,
                 live);
    endtask

    task automatic alloc_random_store();
        word_t       addr;
        store_size_t size;
        addr = $urandom;
        size = store_size_t'($urandom_range(2, 0));
        addr = addr & ~word_t'((1 << size) - 1);
        alloc_op(OP_STORE, '0, size, $urandom, addr, 1'b0, '0, 1'b1);
    endtask

    // every bus write also looks up its own tag to exercise the bypass
    task automatic send_result(input tag_t t);
        cdb_valid      = 1'b1;
        cdb_tag        = t;
        cdb_value      = mdl_value[t];
        cdb_addr       = mdl_addr[t];
        cdb_mispredict = mdl_mp[t];
        cdb_target     = mdl_tgt[t];
        lookup_tag     = t;
        u_chk.expect_lookup(1'b1, mdl_value[t]);
        next_cycle();
        cdb_valid    = 1'b0;
        mdl_ready[t] = 1'b1;
    endtask

    task automatic send_all_random();
        int idx;
        tag_t t;
        while (pending_tags.size() > 0) begin
            idx = $urandom_range(pending_tags.size() - 1, 0);
            t   = pending_tags[idx];
            pending_tags.delete(idx);
            send_result(t);
        end
    endtask

    task automatic lookup_check(input tag_t t);
        lookup_tag = t;
        u_chk.expect_lookup(mdl_ready[t], mdl_value[t]);
        next_cycle();
    endtask

    task automatic wait_drain(input string what);
        int cycles;
        cycles = 0;
        while ((u_chk.pending_events() != 0 || !empty || mem_req || mem_ack) && cycles < 300) begin
            next_cycle();
            cycles++;
        end
        if (u_chk.pending_events() != 0 || !empty || mem_req || mem_ack) begin
            u_chk.report_problem($sformatf("timeout while waiting for %s to retire", what));
        end
    endtask

    task automatic model_flush();
        model_tag = '0;
        pending_tags.delete();
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            mdl_ready[i] = 1'b0;
        end
    endtask

    // memory side of the four-phase store handshake
    initial begin : mem_responder
        int delay;
        int guard;
        mem_ack = 1'b0;
        forever begin
            next_cycle();
            if (mem_req && !mem_ack) begin
                delay = (ack_delays.size() > 0) ? ack_delays.pop_front() : 0;
                repeat (delay) begin
                    next_cycle();
                end
                mem_ack = 1'b1;
                guard   = 0;
                while (mem_req && guard < 50) begin
                    next_cycle();
                    guard++;
                end
                if (mem_req) begin
                    u_chk.report_problem("mem_req never fell after mem_ack");
                end
                mem_ack = 1'b0;
            end
        end
    end

    initial begin : stimulus
        int   seed;
        tag_t br_tag;
        seed = 25956;
        void'($urandom(seed));
        rst_n          = 1'b0;
        alloc_valid    = 1'b0;
        alloc_kind     = OP_REG;
        alloc_dest     = '0;
        alloc_size     = SZ_WORD;
        cdb_valid      = 1'b0;
        cdb_tag        = '0;
        cdb_value      = '0;
        cdb_addr       = '0;
        cdb_mispredict = 1'b0;
        cdb_target     = '0;
        lookup_tag     = '0;
        model_flush();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        u_chk.expect_status(1'b0, '0);
        u_chk.expect_idle();
        next_cycle();
        u_chk.finish_test("reset state");

        for (int i = 0; i < `ROB_DEPTH; i++) begin
            alloc_random_reg(1'b1);
        end
        u_chk.expect_status(1'b1, model_tag);
        next_cycle();
        send_all_random();
        wait_drain("register ops");
        u_chk.finish_test("in-order commit");

        // head stays unwritten so written entries remain visible to lookup
        for (int i = 0; i < 4; i++) begin
            alloc_random_reg(1'b1);
        end
        for (int i = 0; i < 4; i++) begin
            lookup_check(pending_tags[i]);
        end
        for (int i = 3; i >= 1; i--) begin
            send_result(pending_tags[i]);
        end
        for (int i = 0; i < 4; i++) begin
            lookup_check(pending_tags[i]);
        end
        send_result(pending_tags[0]);
        pending_tags.delete();
        wait_drain("lookup ops");
        u_chk.finish_test("operand lookup");

        for (int r = 0; r < 3; r++) begin
            alloc_random_reg(1'b1);
            alloc_random_store();
            alloc_random_reg(1'b1);
            alloc_random_store();
            alloc_random_reg(1'b1);
            send_all_random();
            wait_drain("stores");
        end
        u_chk.finish_test("stores");

        // mispredicted branch, younger results arrive before it resolves
        alloc_random_reg(1'b1);
        alloc_random_reg(1'b1);
        alloc_op(OP_BRANCH, '0, SZ_WORD, '0, '0, 1'b1, $urandom & ~32'h3, 1'b1);
        br_tag = pending_tags.pop_back();
        alloc_random_reg(1'b0);
        alloc_random_reg(1'b0);
        send_all_random();
        send_result(br_tag);
        wait_drain("branch flush");
        model_flush();

        alloc_random_reg(1'b1);
        alloc_op(OP_JALR, reg_idx_t'($urandom_range(31, 1)), SZ_WORD, $urandom, '0, 1'b1,
                 $urandom & ~32'h3, 1'b1);
        br_tag = pending_tags.pop_back();
        alloc_random_reg(1'b0);
        send_all_random();
        send_result(br_tag);
        wait_drain("jalr flush");
        model_flush();

        alloc_random_reg(1'b1);
        alloc_op(OP_BRANCH, '0, SZ_WORD, '0, '0, 1'b0, $urandom & ~32'h3, 1'b1);
        alloc_random_reg(1'b1);
        send_all_random();
        wait_drain("predicted branch");
        u_chk.finish_test("mispredict");

        $display("%0d tests passed, %0d tests failed, %0d checks, %0d errors",
                 u_chk.tests_passed, u_chk.tests_failed, u_chk.check_count,
                 u_chk.error_count);
        if (u_chk.error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+logic
logic/rob_pkg.sv
logic/rob_pointers.sv
logic/rob_entries.sv
logic/store_align.sv
logic/commit_fsm.sv
logic/rob_top.sv
testbench/rob_checker.sv
testbench/rob_tb.sv
